//--- verilog/core_pkg.sv
`default_nettype none

package core_pkg;

  // widths
  localparam int data_width  = 32;
  localparam int addr_width  = 5;
  localparam int num_regs    = 32;
  localparam int shamt_width = 5;   // shift amount bits taken from operand b

  // immediate formats
  localparam logic [1:0] imm5_ze  = 2'b00;
  localparam logic [1:0] imm15_se = 2'b01;
  localparam logic [1:0] imm15_ze = 2'b10;
  localparam logic [1:0] imm20_se = 2'b11;

  // opcodes
  localparam logic [5:0] op_alu  = 6'b100000;  // reg-reg, sub-opcode decides
  localparam logic [5:0] op_addi = 6'b101000;
  localparam logic [5:0] op_andi = 6'b101010;
  localparam logic [5:0] op_xori = 6'b101011;
  localparam logic [5:0] op_ori  = 6'b101100;

  // sub-opcodes for op_alu
  localparam logic [4:0] sub_add = 5'b00000;
  localparam logic [4:0] sub_sub = 5'b00001;
  localparam logic [4:0] sub_and = 5'b00010;
  localparam logic [4:0] sub_xor = 5'b00011;
  localparam logic [4:0] sub_or  = 5'b00100;
  localparam logic [4:0] sub_nor = 5'b00101;
  localparam logic [4:0] sub_slt = 5'b00110;
  localparam logic [4:0] sub_sll = 5'b01100;
  localparam logic [4:0] sub_srl = 5'b01101;
  localparam logic [4:0] sub_sra = 5'b01110;

  // raw immediate fields as they come from the instruction word
  typedef struct packed {
    logic [19:0] imm20;
    logic [14:0] imm15;
    logic [4:0]  imm5;
  } imm_fields_t;

  typedef struct packed {
    logic [5:0] opcode;
    logic [4:0] sub_opcode;
  } alu_op_t;

  // register file addressing and strobes
  typedef struct packed {
    logic [addr_width-1:0] read_address1;
    logic [addr_width-1:0] read_address2;
    logic [addr_width-1:0] write_address;
    logic                  fetch;
    logic                  writeback;
  } reg_ctrl_t;

endpackage

`default_nettype wire

//--- verilog/regfile.sv
`default_nettype none
`timescale 1ns/1ps

module regfile (
  input  logic                             clk,
  input  logic                             reset,
  input  core_pkg::reg_ctrl_t              reg_ctrl,
  input  logic [core_pkg::data_width-1:0]  write_data,
  output logic [core_pkg::data_width-1:0]  read_data1,
  output logic [core_pkg::data_width-1:0]  read_data2
);

  import core_pkg::*;

  logic [data_width-1:0] regs [num_regs];
  logic                  write_en;

  // r0 is never written, so it keeps its reset value of zero
  assign write_en = reg_ctrl.writeback && (reg_ctrl.write_address != '0);

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (write_en) begin
      regs[reg_ctrl.write_address] <= write_data;
    end
  end

  // read ports sample the array before any same-edge write lands
  always_ff @(posedge clk) begin
    if (reset) begin
      read_data1 <= '0;
      read_data2 <= '0;
    end else if (reg_ctrl.fetch) begin
      read_data1 <= regs[reg_ctrl.read_address1];
      read_data2 <= regs[reg_ctrl.read_address2];
    end
  end

endmodule

`default_nettype wire

//--- verilog/imm_extend.sv
`default_nettype none
`timescale 1ns/1ps

module imm_extend (
  input  core_pkg::imm_fields_t            imm,
  input  logic [1:0]                       imm_format,
  output logic [core_pkg::data_width-1:0]  imm_value
);

  import core_pkg::*;

  always_comb begin
    case (imm_format)
      imm5_ze:  imm_value = {{(data_width-5){1'b0}}, imm.imm5};
      imm15_se: imm_value = {{(data_width-15){imm.imm15[14]}}, imm.imm15};
      imm15_ze: imm_value = {{(data_width-15){1'b0}}, imm.imm15};
      imm20_se: imm_value = {{(data_width-20){imm.imm20[19]}}, imm.imm20};
      default:  imm_value = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- verilog/alu32.sv
`default_nettype none
`timescale 1ns/1ps

module alu32 (
  input  logic                             clk,
  input  logic                             reset,
  input  logic                             execute,
  input  core_pkg::alu_op_t                alu_op,
  input  logic [core_pkg::data_width-1:0]  operand_a,
  input  logic [core_pkg::data_width-1:0]  operand_b,
  output logic [core_pkg::data_width-1:0]  alu_result,
  output logic                             overflow
);

  import core_pkg::*;

  logic [data_width-1:0]  sum;
  logic [data_width-1:0]  diff;
  logic [shamt_width-1:0] shamt;
  logic                   add_ovf;
  logic                   sub_ovf;
  logic [data_width-1:0]  next_result;
  logic                   next_overflow;

  assign sum   = operand_a + operand_b;
  assign diff  = operand_a - operand_b;
  assign shamt = operand_b[shamt_width-1:0];

  // same signs in, different sign out
  assign add_ovf = (operand_a[data_width-1] == operand_b[data_width-1]) &&
                   (sum[data_width-1] != operand_a[data_width-1]);
  // opposite signs in, result flips away from a
  assign sub_ovf = (operand_a[data_width-1] != operand_b[data_width-1]) &&
                   (diff[data_width-1] != operand_a[data_width-1]);

  always_comb begin
    next_result   = '0;   // unknown codes give zero
    next_overflow = 1'b0;
    case (alu_op.opcode)
      op_alu: begin
        case (alu_op.sub_opcode)
          sub_add: begin
            next_result   = sum;
            next_overflow = add_ovf;
          end
          sub_sub: begin
            next_result   = diff;
            next_overflow = sub_ovf;
          end
          sub_and: next_result = operand_a & operand_b;
          sub_or:  next_result = operand_a | operand_b;
          sub_xor: next_result = operand_a ^ operand_b;
          sub_nor: next_result = ~(operand_a | operand_b);
          sub_slt: next_result = data_width'($signed(operand_a) < $signed(operand_b));
          sub_sll: next_result = operand_a << shamt;
          sub_srl: next_result = operand_a >> shamt;
          sub_sra: next_result = $signed(operand_a) >>> shamt;
          default: next_result = '0;
        endcase
      end
      // addi is an add, so it flags overflow too
      op_addi: begin
        next_result   = sum;
        next_overflow = add_ovf;
      end
      op_andi: next_result = operand_a & operand_b;
      op_ori:  next_result = operand_a | operand_b;
      op_xori: next_result = operand_a ^ operand_b;
      default: next_result = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      alu_result <= '0;
      overflow   <= 1'b0;
    end else if (execute) begin
      alu_result <= next_result;
      overflow   <= next_overflow;
    end
  end

endmodule

`default_nettype wire

//--- verilog/datapath_top.sv
`default_nettype none
`timescale 1ns/1ps

module datapath_top (
  input  logic                             clk,
  input  logic                             reset,
  input  core_pkg::reg_ctrl_t              reg_ctrl,
  input  core_pkg::imm_fields_t            imm,
  input  logic [1:0]                       imm_format,
  input  logic                             imm_select,  // 1: immediate as operand b
  input  logic                             wb_select,   // 1: write operand b back
  input  logic                             execute,
  input  core_pkg::alu_op_t                alu_op,
  output logic [core_pkg::data_width-1:0]  write_data,
  output logic [core_pkg::data_width-1:0]  alu_result,
  output logic                             overflow
);

  import core_pkg::*;

  logic [data_width-1:0] read_data1;
  logic [data_width-1:0] read_data2;
  logic [data_width-1:0] imm_value;
  logic [data_width-1:0] operand_b;

  regfile u_regfile (
    .clk        (clk),
    .reset      (reset),
    .reg_ctrl   (reg_ctrl),
    .write_data (write_data),
    .read_data1 (read_data1),
    .read_data2 (read_data2)
  );

  imm_extend u_imm_extend (
    .imm        (imm),
    .imm_format (imm_format),
    .imm_value  (imm_value)
  );

  assign operand_b = imm_select ? imm_value : read_data2;

  alu32 u_alu32 (
    .clk        (clk),
    .reset      (reset),
    .execute    (execute),
    .alu_op     (alu_op),
    .operand_a  (read_data1),
    .operand_b  (operand_b),
    .alu_result (alu_result),
    .overflow   (overflow)
  );

  // writeback mux feeds the register file write port
  assign write_data = wb_select ? operand_b : alu_result;

endmodule

`default_nettype wire

//--- verification/datapath_assert.sv
`default_nettype none
`timescale 1ns/1ps

module datapath_assert (
  input logic                             clk,
  input logic                             reset,
  input core_pkg::reg_ctrl_t              reg_ctrl,
  input logic                             execute,
  input core_pkg::alu_op_t                alu_op,
  input logic [core_pkg::data_width-1:0]  read_data1,
  input logic [core_pkg::data_width-1:0]  read_data2,
  input logic [core_pkg::data_width-1:0]  alu_result,
  input logic                             overflow
);

  import core_pkg::*;

  logic is_add_sub;
  int   fail_count = 0;

  // addi counts as an add
  assign is_add_sub = (alu_op.opcode == op_addi) ||
                      (alu_op.opcode == op_alu &&
                       (alu_op.sub_opcode == sub_add || alu_op.sub_opcode == sub_sub));

  overflow_only_add_sub: assert property (@(posedge clk) disable iff (reset)
    execute && !is_add_sub |=> !overflow)
    else begin
      $error("overflow set after an operation other than add or subtract");
      fail_count++;
    end

  alu_holds: assert property (@(posedge clk) disable iff (reset)
    !execute |=> $stable(alu_result) && $stable(overflow))
    else begin
      $error("alu_result or overflow changed without execute");
      fail_count++;
    end

  read_holds: assert property (@(posedge clk) disable iff (reset)
    !reg_ctrl.fetch |=> $stable(read_data1) && $stable(read_data2))
    else begin
      $error("read data changed without fetch");
      fail_count++;
    end

  reg0_port1_zero: assert property (@(posedge clk) disable iff (reset)
    reg_ctrl.fetch && reg_ctrl.read_address1 == '0 |=> read_data1 == '0)
    else begin
      $error("register 0 read nonzero on port 1");
      fail_count++;
    end

  reg0_port2_zero: assert property (@(posedge clk) disable iff (reset)
    reg_ctrl.fetch && reg_ctrl.read_address2 == '0 |=> read_data2 == '0)
    else begin
      $error("register 0 read nonzero on port 2");
      fail_count++;
    end

endmodule

bind datapath_top datapath_assert u_datapath_assert (
  .clk        (clk),
  .reset      (reset),
  .reg_ctrl   (reg_ctrl),
  .execute    (execute),
  .alu_op     (alu_op),
  .read_data1 (read_data1),
  .read_data2 (read_data2),
  .alu_result (alu_result),
  .overflow   (overflow)
);

`default_nettype wire

//--- verification/datapath_tb.sv
`default_nettype none
`timescale 1ns/1ps

module datapath_tb;

  import core_pkg::*;

  localparam int clk_period   = 8;
  localparam int reset_cycles = 16;
  // reset, reg-reg, immediates, overflow, writeback, random mix plus dump
  localparam int total_instr  = 34 + 111 + 64 + 110 + 48 + 332;
  localparam longint max_pos  = (longint'(1) <<< 31) - 1;
  localparam longint min_neg  = -(longint'(1) <<< 31);
  localparam logic [4:0] sub_list [10] = '{sub_add, sub_sub, sub_and, sub_or, sub_xor,
                                           sub_nor, sub_slt, sub_sll, sub_srl, sub_sra};
  localparam logic [5:0] imm_ops [4] = '{op_addi, op_andi, op_ori, op_xori};

  logic                  clk;
  logic                  reset;
  reg_ctrl_t             reg_ctrl;
  imm_fields_t           imm;
  logic [1:0]            imm_format;
  logic                  imm_select;
  logic                  wb_select;
  logic                  execute;
  alu_op_t               alu_op;
  logic [data_width-1:0] write_data;
  logic [data_width-1:0] alu_result;
  logic                  overflow;

  logic [data_width-1:0] model_regs [num_regs];
  logic                  check_en;
  logic [data_width-1:0] exp_result;
  logic                  exp_ovf;
  logic [data_width-1:0] exp_wb;
  string                 test_name;
  int                    errors;

  datapath_top DUT (
    .clk        (clk),
    .reset      (reset),
    .reg_ctrl   (reg_ctrl),
    .imm        (imm),
    .imm_format (imm_format),
    .imm_select (imm_select),
    .wb_select  (wb_select),
    .execute    (execute),
    .alu_op     (alu_op),
    .write_data (write_data),
    .alu_result (alu_result),
    .overflow   (overflow)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  function automatic alu_op_t make_op(input logic [5:0] opc, input logic [4:0] sub);
    alu_op_t o;
    o.opcode     = opc;
    o.sub_opcode = sub;
    return o;
  endfunction

  function automatic logic [4:0] rand_reg();
    return 5'($urandom);
  endfunction

  function automatic imm_fields_t random_fields();
    imm_fields_t f;
    f.imm5  = 5'($urandom);
    f.imm15 = 15'($urandom);
    f.imm20 = 20'($urandom);
    return f;
  endfunction

  function automatic logic [data_width-1:0] expand_imm(input imm_fields_t f,
                                                       input logic [1:0] fmt);
    logic [data_width-1:0] v;
    case (fmt)
      imm5_ze:  v = data_width'(f.imm5);
      imm15_se: v = f.imm15[14] ? (data_width'(f.imm15) | 32'hffff_8000) : data_width'(f.imm15);
      imm15_ze: v = data_width'(f.imm15);
      imm20_se: v = f.imm20[19] ? (data_width'(f.imm20) | 32'hfff0_0000) : data_width'(f.imm20);
      default:  v = '0;
    endcase
    return v;
  endfunction

  // overflow in the top bit, result below it
  function automatic logic [data_width:0] ref_alu(input alu_op_t op,
                                                  input logic [data_width-1:0] a,
                                                  input logic [data_width-1:0] b);
    longint                sa;
    longint                sb;
    longint                wide;
    logic [data_width-1:0] r;
    logic                  v;
    logic [4:0]            sh;
    sa = $signed(a);
    sb = $signed(b);
    sh = b[4:0];
    r  = '0;
    v  = 1'b0;
    if (op.opcode == op_addi || (op.opcode == op_alu && op.sub_opcode == sub_add)) begin
      wide = sa + sb;
      r    = a + b;
      v    = (wide > max_pos) || (wide < min_neg);  // true sum leaves the 32-bit range
    end else if (op.opcode == op_alu && op.sub_opcode == sub_sub) begin
      wide = sa - sb;
      r    = a - b;
      v    = (wide > max_pos) || (wide < min_neg);
    end else if (op.opcode == op_alu) begin
      case (op.sub_opcode)
        sub_and: r = a & b;
        sub_or:  r = a | b;
        sub_xor: r = a ^ b;
        sub_nor: r = ~(a | b);
        sub_slt: r = (sa < sb) ? 32'd1 : 32'd0;
        sub_sll: r = a << sh;
        sub_srl: r = a >> sh;
        sub_sra: r = (a >> sh) | (a[31] ? ~({data_width{1'b1}} >> sh) : '0);
        default: r = '0;
      endcase
    end else if (op.opcode == op_andi) begin
      r = a & b;
    end else if (op.opcode == op_ori) begin
      r = a | b;
    end else if (op.opcode == op_xori) begin
      r = a ^ b;
    end
    return {v, r};
  endfunction

  task automatic fail_now(input string msg);
    errors++;
    $display("%s", msg);
    $display("SIMULATION FAILED");
    $fatal(1, "stopping at first error");
  endtask

  // fetch, execute, writeback, then one idle cycle
  task automatic run_instr(input alu_op_t op, input logic [4:0] ra1, input logic [4:0] ra2,
                           input logic [4:0] wa, input imm_fields_t fields,
                           input logic [1:0] fmt, input logic isel, input logic wsel,
                           input logic wb);
    logic [data_width-1:0] opb;
    logic [data_width:0]   res;
    opb = isel ? expand_imm(fields, fmt) : model_regs[ra2];
    res = ref_alu(op, model_regs[ra1], opb);
    reg_ctrl.read_address1 = ra1;
    reg_ctrl.read_address2 = ra2;
    reg_ctrl.write_address = wa;
    reg_ctrl.fetch         = 1'b1;
    alu_op     = op;
    imm        = fields;
    imm_format = fmt;
    imm_select = isel;
    wb_select  = wsel;
    @(posedge clk);
    #1;
    reg_ctrl.fetch = 1'b0;
    execute        = 1'b1;
    @(posedge clk);
    #1;
    execute            = 1'b0;
    reg_ctrl.writeback = wb;
    exp_result = res[data_width-1:0];
    exp_ovf    = res[data_width];
    exp_wb     = wsel ? opb : res[data_width-1:0];
    check_en   = 1'b1;
    @(posedge clk);
    #1;
    reg_ctrl.writeback = 1'b0;
    check_en           = 1'b0;
    if (wb && wa != 5'd0) model_regs[wa] = exp_wb;
    @(posedge clk);
    #1;
  endtask

  task automatic load_reg(input logic [4:0] r, input imm_fields_t f, input logic [1:0] fmt);
    run_instr(make_op(op_alu, sub_add), 5'd0, 5'd0, r, f, fmt, 1'b1, 1'b1, 1'b1);
  endtask

  task automatic read_reg(input logic [4:0] r);
    run_instr(make_op(op_alu, sub_or), r, 5'd0, 5'd0, '0, imm5_ze, 1'b0, 1'b0, 1'b0);
  endtask

  // imm20 value shifted up so the full 32-bit range shows up
  task automatic load_wide(input logic [4:0] r);
    imm_fields_t f;
    f = random_fields();
    load_reg(r, f, imm20_se);
    f.imm5 = 5'($urandom_range(12, 0));
    run_instr(make_op(op_alu, sub_sll), r, 5'd0, r, f, imm5_ze, 1'b1, 1'b0, 1'b1);
  endtask

  task automatic check_ovf_set();
    assert (overflow === 1'b1)
      else fail_now($sformatf("error: %s overflow expected 1 actual %b", test_name, overflow));
  endtask

  always @(negedge clk) begin
    assert (DUT.u_datapath_assert.fail_count == 0)
      else fail_now($sformatf("%s: a bound datapath assertion failed", test_name));
    if (check_en) begin
      assert (alu_result === exp_result)
        else fail_now($sformatf("error: %s alu_result expected %h actual %h",
                                test_name, exp_result, alu_result));
      assert (overflow === exp_ovf)
        else fail_now($sformatf("error: %s overflow expected %b actual %b",
                                test_name, exp_ovf, overflow));
      assert (write_data === exp_wb)
        else fail_now($sformatf("error: %s write_data expected %h actual %h",
                                test_name, exp_wb, write_data));
    end
  end

  initial begin
    #((total_instr * 4 + reset_cycles + 100) * clk_period);
    $display("error: watchdog timeout, the tests did not finish in time");
    $display("SIMULATION FAILED");
    $fatal(1, "timeout");
  end

  initial begin
    alu_op_t     op;
    imm_fields_t fields;
    logic [4:0]  wa;
    int          idx;
    void'($urandom(75));
    errors      = 0;
    check_en    = 1'b0;
    reset       = 1'b1;
    reg_ctrl    = '0;
    imm         = '0;
    imm_format  = imm5_ze;
    imm_select  = 1'b0;
    wb_select   = 1'b0;
    execute     = 1'b0;
    alu_op      = '0;
    for (int r = 0; r < num_regs; r++) model_regs[r] = '0;
    repeat (reset_cycles) @(posedge clk);
    #1;
    reset = 1'b0;

    test_name = "reset_state";
    for (int r = 0; r < num_regs; r++) read_reg(5'(r));
    run_instr(make_op(op_alu, sub_add), 5'd0, 5'd0, 5'd0, '0, imm5_ze, 1'b0, 1'b0, 1'b0);
    run_instr(make_op(6'h3f, 5'h1f), 5'd0, 5'd0, 5'd0, random_fields(), imm20_se,
              1'b1, 1'b0, 1'b0);  // unknown code

    test_name = "reg_reg_ops";
    for (int r = 1; r < num_regs; r++) load_reg(5'(r), random_fields(), imm20_se);
    for (int s = 0; s < 10; s++) begin
      for (int k = 0; k < 8; k++) begin
        run_instr(make_op(op_alu, sub_list[s]), rand_reg(), rand_reg(), rand_reg(),
                  random_fields(), imm5_ze, 1'b0, 1'b0, 1'b1);
      end
    end

    test_name = "imm_formats";
    for (int f = 0; f < 4; f++) begin
      for (int o = 0; o < 4; o++) begin
        for (int k = 0; k < 4; k++) begin
          fields = random_fields();
          if (k[1]) begin  // top bit set in every field
            fields.imm5[4]   = 1'b1;
            fields.imm15[14] = 1'b1;
            fields.imm20[19] = 1'b1;
          end
          run_instr(make_op(imm_ops[o], sub_add), rand_reg(), rand_reg(), rand_reg(),
                    fields, 2'(f), k[0], 1'b0, 1'b1);
        end
      end
    end

    test_name = "overflow";
    fields = '0;
    fields.imm20 = '1;
    load_reg(5'd1, fields, imm20_se);
    load_reg(5'd2, fields, imm20_se);
    fields.imm5 = 5'd1;
    run_instr(make_op(op_alu, sub_srl), 5'd1, 5'd0, 5'd1, fields, imm5_ze, 1'b1, 1'b0, 1'b1);
    load_reg(5'd3, fields, imm5_ze);
    fields.imm5 = 5'd31;
    run_instr(make_op(op_alu, sub_sll), 5'd2, 5'd0, 5'd2, fields, imm5_ze, 1'b1, 1'b0, 1'b1);
    run_instr(make_op(op_alu, sub_add), 5'd1, 5'd3, 5'd0, '0, imm5_ze, 1'b0, 1'b0, 1'b0);
    check_ovf_set();  // max + 1
    run_instr(make_op(op_alu, sub_sub), 5'd2, 5'd3, 5'd0, '0, imm5_ze, 1'b0, 1'b0, 1'b0);
    check_ovf_set();  // min - 1
    run_instr(make_op(op_alu, sub_sub), 5'd1, 5'd2, 5'd0, '0, imm5_ze, 1'b0, 1'b0, 1'b0);
    check_ovf_set();
    run_instr(make_op(op_alu, sub_add), 5'd2, 5'd2, 5'd0, '0, imm5_ze, 1'b0, 1'b0, 1'b0);
    check_ovf_set();
    fields.imm5 = 5'd1;
    run_instr(make_op(op_addi, sub_add), 5'd1, 5'd0, 5'd0, fields, imm5_ze, 1'b1, 1'b0, 1'b0);
    check_ovf_set();
    for (int k = 0; k < 20; k++) begin
      load_wide(5'd4);
      load_wide(5'd5);
      run_instr(make_op(op_alu, k[0] ? sub_sub : sub_add), 5'd4, 5'd5, 5'd6, '0, imm5_ze,
                1'b0, 1'b0, 1'b1);
    end

    test_name = "writeback_path";
    for (int k = 0; k < 8; k++) begin
      wa = 5'($urandom_range(31, 1));
      run_instr(make_op(op_alu, sub_xor), rand_reg(), rand_reg(), wa, random_fields(),
                imm15_se, 1'b0, 1'b0, 1'b1);
      read_reg(wa);
      wa = 5'($urandom_range(31, 1));
      run_instr(make_op(op_alu, sub_add), rand_reg(), rand_reg(), wa, random_fields(),
                imm15_se, 1'b1, 1'b1, 1'b1);
      read_reg(wa);
      run_instr(make_op(op_alu, sub_nor), rand_reg(), rand_reg(), 5'd0, random_fields(),
                imm20_se, 1'b0, 1'b0, 1'b1);
      read_reg(5'd0);
    end

    test_name = "random_mix";
    for (int k = 0; k < 300; k++) begin
      idx = $urandom_range(13, 0);
      op  = (idx < 10) ? make_op(op_alu, sub_list[idx]) : make_op(imm_ops[idx-10], sub_add);
      run_instr(op, rand_reg(), rand_reg(), rand_reg(), random_fields(), 2'($urandom),
                1'($urandom), 1'($urandom), 1'b1);
    end
    test_name = "register_dump";
    for (int r = 0; r < num_regs; r++) read_reg(5'(r));

    if (errors == 0 && DUT.u_datapath_assert.fail_count == 0) begin
      $display("SIMULATION PASSED");
      $finish;
    end else begin
      $display("SIMULATION FAILED");
      $fatal(1, "checks failed");
    end
  end

endmodule

`default_nettype wire

//--- filelist.f
verilog/core_pkg.sv
verilog/regfile.sv
verilog/imm_extend.sv
verilog/alu32.sv
verilog/datapath_top.sv
verification/datapath_assert.sv
verification/datapath_tb.sv

//--- Bender.yml
package:
  name: datapath

dependencies: {}

sources:
  - files:
      - verilog/core_pkg.sv
      - verilog/regfile.sv
      - verilog/imm_extend.sv
      - verilog/alu32.sv
      - verilog/datapath_top.sv
  - target: test
    files:
      - verification/datapath_assert.sv
      - verification/datapath_tb.sv
